//--- include/icache_cfg.svh
`ifndef ICACHE_CFG_SVH
`define ICACHE_CFG_SVH

// fetch address width
// also the width of one fetch word
`define ICACHE_ADDR_W 32

// byte offset inside a 64 byte line
`define ICACHE_OFS_W 6

// 128 lines
`define ICACHE_IDX_W 7

// what is left of the address above index and offset
`define ICACHE_TAG_W 19

// 32-bit words per line, so one burst is this many beats
`define ICACHE_BEATS 16

// word address into the data array, line index on top of beat
`define ICACHE_ARR_AW (`ICACHE_IDX_W + $clog2(`ICACHE_BEATS))

// top address nibble of the uncached region
`define ICACHE_UNC_HI 4'hA

`endif

//--- run.sh
#!/bin/sh
# build and run the icache testbench with verilator
# a $fatal in the testbench gives a nonzero exit status
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f sim.f --top-module icache_tb -o icache_sim
./obj_dir/icache_sim

//--- sim.f
+incdir+include
src/icache_pkg.sv
src/icache_refill_if.sv
src/icache_data_array.sv
src/icache_lookup.sv
src/icache_refill.sv
src/icache_top.sv
tb/icache_tb.sv

//--- src/icache_data_array.sv
`timescale 1ns/1ps
`include "icache_cfg.svh"

module icache_data_array (
  input  logic                      clk,
  input  logic                      we_i,
  input  logic [`ICACHE_ARR_AW-1:0] waddr_i,
  input  icache_pkg::word_t         wdata_i,
  input  logic [`ICACHE_ARR_AW-1:0] raddr_i,
  output icache_pkg::word_t         rdata_o
);

  // 128 lines of 16 words
  // stale words are never served, valid bits live in the lookup stage
  icache_pkg::word_t mem_q [2**`ICACHE_ARR_AW];

  // one fill beat per write
  always_ff @(posedge clk) begin
    if (we_i) begin
      mem_q[waddr_i] <= wdata_i;
    end
  end

  // combinational read
  // the hit decision uses it in the same cycle
  assign rdata_o = mem_q[raddr_i];

  // a fill beat always lands on a known word
  a_waddr_known: assert property (@(posedge clk)
    we_i |-> !$isunknown(waddr_i));

endmodule

//--- src/icache_lookup.sv
`timescale 1ns/1ps
`include "icache_cfg.svh"

module icache_lookup (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     fetch_valid_i,
  input  icache_pkg::addr_t        fetch_addr_i,
  output icache_pkg::word_t        fetch_rdata_o,
  output logic                     fetch_rvalid_o,
  output logic [`ICACHE_ARR_AW-1:0] rd_addr_o,
  input  icache_pkg::word_t        rd_data_i,
  icache_refill_if.lookup          rf
);

  // wait covers both the line fill and the uncached read
  typedef enum logic [1:0] {
    LK_IDLE,
    LK_LOOKUP,
    LK_WAIT
  } lk_state_t;

  lk_state_t                      state_q;
  icache_pkg::addr_t              addr_q;
  icache_pkg::tag_t               tag_mem [2**`ICACHE_IDX_W];
  logic [2**`ICACHE_IDX_W-1:0]    valid_q;

  icache_pkg::tag_t               cur_tag;
  icache_pkg::idx_t               cur_idx;
  icache_pkg::beat_t              cur_beat;
  logic                           uncached;
  logic                           hit;
  logic                           unc_done;

  // split the captured address
  assign cur_tag  = addr_q[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];
  assign cur_idx  = addr_q[`ICACHE_OFS_W +: `ICACHE_IDX_W];
  assign cur_beat = addr_q[2 +: $bits(icache_pkg::beat_t)];

  // region decode on the top nibble
  assign uncached = (addr_q[`ICACHE_ADDR_W-1 -: 4] == `ICACHE_UNC_HI);

  // tag compare against the registered address
  assign hit = (state_q == LK_LOOKUP) && !uncached && valid_q[cur_idx] &&
               (tag_mem[cur_idx] == cur_tag);

  // uncached word arrives with done
  assign unc_done = (state_q == LK_WAIT) && rf.done && rf.req_uncached;

  assign fetch_rvalid_o = hit | unc_done;
  assign fetch_rdata_o  = uncached ? rf.unc_word : rd_data_i;

  // word read from the data array, same cycle
  assign rd_addr_o = {cur_idx, cur_beat};

  // request to the refill stage
  assign rf.req_valid    = (state_q == LK_WAIT);
  assign rf.req_addr     = addr_q;
  assign rf.req_uncached = uncached;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= LK_IDLE;
    end else begin
      case (state_q)
        LK_IDLE: begin
          if (fetch_valid_i) begin
            state_q <= LK_LOOKUP;
          end
        end
        LK_LOOKUP: begin
          // a hit with the next request presented keeps the pipe full
          if (!hit) begin
            state_q <= LK_WAIT;
          end else if (!fetch_valid_i) begin
            state_q <= LK_IDLE;
          end
        end
        LK_WAIT: begin
          if (rf.done) begin
            if (!rf.req_uncached) begin
              // same address again, hits now
              state_q <= LK_LOOKUP;
            end else if (fetch_valid_i) begin
              state_q <= LK_LOOKUP;
            end else begin
              state_q <= LK_IDLE;
            end
          end
        end
        default: state_q <= LK_IDLE;
      endcase
    end
  end

  // next request taken in idle or with any response
  always_ff @(posedge clk) begin
    if ((state_q == LK_IDLE) || fetch_rvalid_o) begin
      addr_q <= fetch_addr_i;
    end
  end

  // tag written once the whole line is in
  always_ff @(posedge clk) begin
    if (rf.tag_we) begin
      tag_mem[cur_idx] <= cur_tag;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
    end else if (rf.tag_we) begin
      valid_q[cur_idx] <= 1'b1;
    end
  end

  // during a refill the only response is the uncached one with done
  a_rvalid_in_refill: assert property (@(posedge clk) disable iff (rst)
    fetch_rvalid_o && rf.req_valid |-> rf.done && !rf.tag_we);

  // request held until the refill stage answers
  a_req_hold: assert property (@(posedge clk) disable iff (rst)
    rf.req_valid && !rf.done |=> rf.req_valid);

endmodule

//--- src/icache_pkg.sv
`include "icache_cfg.svh"

package icache_pkg;

  // full fetch or memory address
  typedef logic [`ICACHE_ADDR_W-1:0] addr_t;

  // address fields
  typedef logic [`ICACHE_TAG_W-1:0] tag_t;
  typedef logic [`ICACHE_IDX_W-1:0] idx_t;

  // word position inside a line, also the burst beat count
  typedef logic [$clog2(`ICACHE_BEATS)-1:0] beat_t;

  // one instruction word
  typedef logic [`ICACHE_ADDR_W-1:0] word_t;

  // refill stage FSM
  // single is the one-beat uncached read
  typedef enum logic [1:0] {
    RF_IDLE,
    RF_BURST,
    RF_SINGLE
  } refill_state_t;

endpackage

//--- src/icache_refill.sv
`timescale 1ns/1ps
`include "icache_cfg.svh"

module icache_refill (
  input  logic                      clk,
  input  logic                      rst,
  icache_refill_if.refill           rf,
  output logic                      mem_arvalid_o,
  output icache_pkg::addr_t         mem_araddr_o,
  output logic [7:0]                mem_arlen_o,
  input  logic                      mem_rvalid_i,
  input  icache_pkg::word_t         mem_rdata_i,
  output logic                      fill_we_o,
  output logic [`ICACHE_ARR_AW-1:0] fill_addr_o,
  output icache_pkg::word_t         fill_data_o
);

  icache_pkg::refill_state_t state_q;
  icache_pkg::addr_t         araddr_q;
  icache_pkg::beat_t         beat_q;
  icache_pkg::word_t         unc_q;
  logic                      done_q;
  logic                      tag_we_q;

  logic                      start;
  logic                      beat_ok;
  logic                      last_beat;

  // done_q blocks a restart while req_valid is still up in the done cycle
  assign start = (state_q == icache_pkg::RF_IDLE) && rf.req_valid && !done_q;

  // valid held for the whole transfer
  assign mem_arvalid_o = (state_q != icache_pkg::RF_IDLE);
  assign mem_araddr_o  = araddr_q;
  assign mem_arlen_o   = (state_q == icache_pkg::RF_BURST) ? 8'(`ICACHE_BEATS - 1) : 8'd0;

  // memory data valid accepts one beat
  assign beat_ok   = mem_arvalid_o && mem_rvalid_i;
  assign last_beat = beat_ok && ((state_q == icache_pkg::RF_SINGLE) ||
                     (beat_q == icache_pkg::beat_t'(`ICACHE_BEATS - 1)));

  // every fill beat goes straight into the data array
  assign fill_we_o   = beat_ok && (state_q == icache_pkg::RF_BURST);
  assign fill_addr_o = {araddr_q[`ICACHE_OFS_W +: `ICACHE_IDX_W], beat_q};
  assign fill_data_o = mem_rdata_i;

  assign rf.done     = done_q;
  assign rf.tag_we   = tag_we_q;
  assign rf.unc_word = unc_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q  <= icache_pkg::RF_IDLE;
      beat_q   <= '0;
      done_q   <= 1'b0;
      tag_we_q <= 1'b0;
    end else begin
      // finish pulses come one cycle after the last beat
      done_q   <= last_beat;
      tag_we_q <= last_beat && (state_q == icache_pkg::RF_BURST);
      case (state_q)
        icache_pkg::RF_IDLE: begin
          if (start) begin
            beat_q  <= '0;
            state_q <= rf.req_uncached ? icache_pkg::RF_SINGLE : icache_pkg::RF_BURST;
          end
        end
        icache_pkg::RF_BURST: begin
          // stalls simply hold the counter
          if (beat_ok) begin
            beat_q <= beat_q + 1'b1;
            if (last_beat) begin
              state_q <= icache_pkg::RF_IDLE;
            end
          end
        end
        icache_pkg::RF_SINGLE: begin
          if (beat_ok) begin
            state_q <= icache_pkg::RF_IDLE;
          end
        end
        default: state_q <= icache_pkg::RF_IDLE;
      endcase
    end
  end

  // line fills start line aligned, uncached reads use the exact address
  always_ff @(posedge clk) begin
    if (start) begin
      if (rf.req_uncached) begin
        araddr_q <= rf.req_addr;
      end else begin
        araddr_q <= {rf.req_addr[`ICACHE_ADDR_W-1:`ICACHE_OFS_W], {`ICACHE_OFS_W{1'b0}}};
      end
    end
  end

  // uncached word kept for the done cycle
  always_ff @(posedge clk) begin
    if (beat_ok && (state_q == icache_pkg::RF_SINGLE)) begin
      unc_q <= mem_rdata_i;
    end
  end

  // no early drop of the memory request
  a_arvalid_hold: assert property (@(posedge clk) disable iff (rst)
    mem_arvalid_o && !last_beat |=> mem_arvalid_o);

endmodule

//--- src/icache_refill_if.sv
`timescale 1ns/1ps

interface icache_refill_if;

  // lookup stage asks for memory, held until done
  logic              req_valid;
  logic              req_uncached;
  icache_pkg::addr_t req_addr;

  // refill stage finished, one cycle
  logic              done;
  // line fill complete, tag and valid bit may be written
  logic              tag_we;
  // uncached read data, good together with done
  icache_pkg::word_t unc_word;

  modport lookup (
    output req_valid,
    output req_addr,
    output req_uncached,
    input  done,
    input  tag_we,
    input  unc_word
  );

  modport refill (
    input  req_valid,
    input  req_addr,
    input  req_uncached,
    output done,
    output tag_we,
    output unc_word
  );

endinterface

//--- src/icache_top.sv
`timescale 1ns/1ps
`include "icache_cfg.svh"

module icache_top (
  input  logic              clk,
  input  logic              rst,
  // cpu fetch port
  input  logic              fetch_valid_i,
  input  icache_pkg::addr_t fetch_addr_i,
  output icache_pkg::word_t fetch_rdata_o,
  output logic              fetch_rvalid_o,
  // memory read port
  output logic              mem_arvalid_o,
  output icache_pkg::addr_t mem_araddr_o,
  output logic [7:0]        mem_arlen_o,
  input  logic              mem_rvalid_i,
  input  icache_pkg::word_t mem_rdata_i
);

  // lookup to refill handshake
  icache_refill_if rf_bus ();

  // data array read side
  logic [`ICACHE_ARR_AW-1:0] rd_addr;
  icache_pkg::word_t         rd_data;

  // data array fill side
  logic                      fill_we;
  logic [`ICACHE_ARR_AW-1:0] fill_addr;
  icache_pkg::word_t         fill_data;

  icache_lookup u_lookup (
    .clk           (clk),
    .rst           (rst),
    .fetch_valid_i (fetch_valid_i),
    .fetch_addr_i  (fetch_addr_i),
    .fetch_rdata_o (fetch_rdata_o),
    .fetch_rvalid_o(fetch_rvalid_o),
    .rd_addr_o     (rd_addr),
    .rd_data_i     (rd_data),
    .rf            (rf_bus.lookup)
  );

  icache_refill u_refill (
    .clk          (clk),
    .rst          (rst),
    .rf           (rf_bus.refill),
    .mem_arvalid_o(mem_arvalid_o),
    .mem_araddr_o (mem_araddr_o),
    .mem_arlen_o  (mem_arlen_o),
    .mem_rvalid_i (mem_rvalid_i),
    .mem_rdata_i  (mem_rdata_i),
    .fill_we_o    (fill_we),
    .fill_addr_o  (fill_addr),
    .fill_data_o  (fill_data)
  );

  icache_data_array u_data (
    .clk    (clk),
    .we_i   (fill_we),
    .waddr_i(fill_addr),
    .wdata_i(fill_data),
    .raddr_i(rd_addr),
    .rdata_o(rd_data)
  );

endmodule

//--- tb/icache_tb.sv
`timescale 1ns/1ps
`include "icache_cfg.svh"

module icache_tb;

  localparam int PERIOD = 100;
  // cold fill, line walk, uncached, conflicts, random
  localparam int N_RAND = 24;
  localparam int N_REQ = 1 + `ICACHE_BEATS + 4 + 4 + N_RAND;
  localparam int WATCHDOG_NS = (N_REQ * 40 + 10) * PERIOD;
  localparam int FILL_LEN = `ICACHE_BEATS - 1;
  localparam icache_pkg::word_t MODEL_KEY = 32'h5A5A_0000;

  logic clk = 1'b0;
  logic rst;
  logic fetch_valid_i;
  icache_pkg::addr_t fetch_addr_i;
  icache_pkg::word_t fetch_rdata_o;
  logic fetch_rvalid_o;
  logic mem_arvalid_o;
  icache_pkg::addr_t mem_araddr_o;
  logic [7:0] mem_arlen_o;
  logic mem_rvalid_i;
  icache_pkg::word_t mem_rdata_i;

  // stimulus and observed memory traffic
  icache_pkg::addr_t stream_q[$];
  icache_pkg::addr_t rand_q[$];
  int resp_cyc_q[$];
  int stream_start_cyc;
  int cyc = 0;
  logic [31:0] rng;
  logic xfer_active = 1'b0;
  int xfer_count = 0;
  int beats = 0;
  int last_beats = 0;
  int last_len = 0;
  int stall_cycles = 0;
  icache_pkg::addr_t last_addr = '0;
  // fetch address whose response is awaited
  icache_pkg::addr_t pend_addr = '0;

  icache_top uut (
    .clk           (clk),
    .rst           (rst),
    .fetch_valid_i (fetch_valid_i),
    .fetch_addr_i  (fetch_addr_i),
    .fetch_rdata_o (fetch_rdata_o),
    .fetch_rvalid_o(fetch_rvalid_o),
    .mem_arvalid_o (mem_arvalid_o),
    .mem_araddr_o  (mem_araddr_o),
    .mem_arlen_o   (mem_arlen_o),
    .mem_rvalid_i  (mem_rvalid_i),
    .mem_rdata_i   (mem_rdata_i)
  );

  always #(PERIOD / 2) clk = ~clk;

  always @(posedge clk) cyc <= cyc + 1;

  task automatic abort_run();
    $display("TESTS FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic stop_with_reason(input string msg);
    $display("%0t ns: %s", $time, msg);
    abort_run();
  endtask

  task automatic report_mismatch(input string sig, input logic [31:0] exp,
                                 input logic [31:0] act);
    $display("ERR t=%0t %s expected=%h actual=%h", $time, sig, exp, act);
    abort_run();
  endtask

  // memory contents, the word at address a
  function automatic icache_pkg::word_t model_word(input icache_pkg::addr_t a);
    return a ^ MODEL_KEY;
  endfunction

  // first byte of the 64 byte line holding a
  function automatic icache_pkg::addr_t line_base(input icache_pkg::addr_t a);
    return a & 32'hFFFF_FFC0;
  endfunction

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // memory model, data for the next beat plus random stalls
  initial begin
    icache_pkg::addr_t a;
    mem_rvalid_i = 1'b0;
    mem_rdata_i  = '0;
    rng = 32'd14;
    a = '0;
    // random fetch list built up front, mixes misses, hits and uncached
    for (int i = 0; i < N_RAND; i++) begin
      rng = xorshift32(rng);
      if (rng[31:29] == 3'd0) begin
        a = 32'hA000_0000 | (rng & 32'h000F_FFFC);
      end else if ((i > 0) && (rng[28:27] == 2'd0)) begin
        a = a + 32'd4;
      end else begin
        a = rng & 32'h0000_7FFC;
      end
      rand_q.push_back(a);
    end
    forever begin
      @(posedge clk);
      #1;
      rng = xorshift32(rng);
      // roughly one cycle in four stalls
      mem_rvalid_i = mem_arvalid_o && (rng[1:0] != 2'd0);
      mem_rdata_i  = model_word(mem_araddr_o + 32'(beats * 4));
    end
  end

  // transfer monitor, sampled mid cycle
  always @(negedge clk) begin
    if (!rst) begin
      if (mem_arvalid_o) begin
        if (!xfer_active) begin
          xfer_active = 1'b1;
          xfer_count  = xfer_count + 1;
          last_addr   = mem_araddr_o;
          last_len    = int'(mem_arlen_o);
          // region of the awaited fetch picks single read or line fill
          if (pend_addr[31:28] == `ICACHE_UNC_HI) begin
            assert (last_len == 0)
              else report_mismatch("mem_arlen_o", 0, last_len);
            assert (mem_araddr_o == pend_addr)
              else report_mismatch("mem_araddr_o", pend_addr, mem_araddr_o);
          end else begin
            assert (last_len == FILL_LEN)
              else report_mismatch("mem_arlen_o", FILL_LEN, last_len);
            assert (mem_araddr_o == line_base(pend_addr))
              else report_mismatch("mem_araddr_o", line_base(pend_addr), mem_araddr_o);
          end
        end
        if (mem_rvalid_i) begin
          beats = beats + 1;
        end else begin
          stall_cycles = stall_cycles + 1;
        end
      end else if (xfer_active) begin
        // exactly arlen + 1 beats per transfer
        assert (beats == last_len + 1)
          else report_mismatch("accepted beats", last_len + 1, beats);
        last_beats  = beats;
        beats       = 0;
        xfer_active = 1'b0;
      end
    end
  end

  // request fields stay put while valid is up
  a_ar_stable: assert property (@(posedge clk) disable iff (rst)
    mem_arvalid_o && $past(mem_arvalid_o) |-> $stable(mem_araddr_o) && $stable(mem_arlen_o))
    else stop_with_reason("memory request changed in the middle of a transfer");

  // no fetch answer while memory is busy
  a_rvalid_mem_idle: assert property (@(posedge clk) disable iff (rst)
    !(fetch_rvalid_o && mem_arvalid_o))
    else stop_with_reason("fetch response while a memory transfer was open");

  // next address goes up in the cycle the previous one is answered
  task automatic run_stream();
    int n;
    int nxt;
    icache_pkg::word_t exp;
    n = stream_q.size();
    resp_cyc_q.delete();
    stream_start_cyc = cyc;
    fetch_valid_i = 1'b1;
    fetch_addr_i  = stream_q[0];
    // idle stage takes the first one at this edge
    @(posedge clk);
    #1;
    nxt = 1;
    for (int got = 0; got < n; got++) begin
      pend_addr = stream_q[got];
      if (nxt < n) begin
        fetch_addr_i = stream_q[nxt];
      end else begin
        fetch_valid_i = 1'b0;
      end
      do begin
        @(negedge clk);
      end while (!fetch_rvalid_o);
      resp_cyc_q.push_back(cyc);
      exp = model_word(stream_q[got]);
      assert (fetch_rdata_o == exp)
        else report_mismatch("fetch_rdata_o", exp, fetch_rdata_o);
      nxt++;
      @(posedge clk);
      #1;
    end
  endtask

  task automatic fetch_single(input icache_pkg::addr_t a);
    stream_q.delete();
    stream_q.push_back(a);
    run_stream();
  endtask

  task automatic check_last_xfer(input int exp_count, input icache_pkg::addr_t exp_addr,
                                 input int exp_len);
    assert (xfer_count == exp_count)
      else report_mismatch("memory transfers", exp_count, xfer_count);
    assert (last_addr == exp_addr)
      else report_mismatch("mem_araddr_o", exp_addr, last_addr);
    assert (last_len == exp_len)
      else report_mismatch("mem_arlen_o", exp_len, last_len);
    assert (last_beats == exp_len + 1)
      else report_mismatch("accepted beats", exp_len + 1, last_beats);
  endtask

  initial begin
    #(WATCHDOG_NS);
    stop_with_reason("watchdog expired before all fetches were served");
  end

  initial begin
    int bursts;
    rst = 1'b1;
    fetch_valid_i = 1'b0;
    fetch_addr_i  = '0;
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;

    // quiet outputs after reset
    repeat (3) begin
      @(negedge clk);
      assert (!fetch_rvalid_o)
        else report_mismatch("fetch_rvalid_o", 32'd0, 32'(fetch_rvalid_o));
      assert (!mem_arvalid_o)
        else report_mismatch("mem_arvalid_o", 32'd0, 32'(mem_arvalid_o));
    end
    @(posedge clk);
    #1;

    // cold miss fills line 0x1200
    bursts = xfer_count;
    fetch_single(32'h0000_1238);
    check_last_xfer(bursts + 1, 32'h0000_1200, FILL_LEN);

    // every word of that line, back to back, no memory traffic
    bursts = xfer_count;
    stream_q.delete();
    for (int i = 0; i < `ICACHE_BEATS; i++) begin
      stream_q.push_back(32'h0000_1200 + 32'(((i * 7) % 16) * 4));
    end
    run_stream();
    assert (xfer_count == bursts)
      else report_mismatch("memory transfers", bursts, xfer_count);
    assert (resp_cyc_q[0] == stream_start_cyc + 1)
      else stop_with_reason("first hit not answered in the cycle after capture");
    for (int i = 1; i < `ICACHE_BEATS; i++) begin
      assert (resp_cyc_q[i] == resp_cyc_q[i-1] + 1)
        else stop_with_reason("back-to-back hits did not return on consecutive cycles");
    end

    // uncached reads go to memory every time
    bursts = xfer_count;
    fetch_single(32'hA000_0124);
    check_last_xfer(bursts + 1, 32'hA000_0124, 0);
    fetch_single(32'hA000_0124);
    check_last_xfer(bursts + 2, 32'hA000_0124, 0);
    // cached hit queued behind an uncached read
    stream_q.delete();
    stream_q.push_back(32'hA000_0F00);
    stream_q.push_back(32'h0000_1204);
    run_stream();
    check_last_xfer(bursts + 3, 32'hA000_0F00, 0);

    // same index 0x48, two tags, each swap refills
    for (int i = 0; i < 4; i++) begin
      bursts = xfer_count;
      if ((i % 2) == 0) begin
        fetch_single(32'h0000_3208);
        check_last_xfer(bursts + 1, 32'h0000_3200, FILL_LEN);
      end else begin
        fetch_single(32'h0000_1208);
        check_last_xfer(bursts + 1, 32'h0000_1200, FILL_LEN);
      end
    end

    // random mix under stalls
    stream_q = rand_q;
    run_stream();
    assert (stall_cycles > 0)
      else stop_with_reason("memory model never stalled a beat");

    $display("TESTS PASSED");
    $finish;
  end

endmodule
